/* common/sound_pkg.sv */
package sound_pkg;

  // sample and address widths
  typedef logic [7:0]  sample8_t;
  typedef logic [15:0] audio16_t;
  typedef logic [7:0]  port_addr_t;

  // simplified cpu bus, qualifiers are single-cycle strobes
  typedef struct packed {
    port_addr_t addr;
    sample8_t   wdata;
    logic       iorq;
    logic       rd;
    logic       wr;
  } cpu_bus_t;

  typedef struct packed {
    audio16_t left;
    audio16_t right;
  } stereo_sample_t;

  localparam int NUM_CHANNELS = 4;

  // soundrive channel ports, index is the channel number
  localparam port_addr_t COVOX_PORTS [NUM_CHANNELS] = '{
    8'h0F,
    8'h1F,
    8'h4F,
    8'h5F
  };

  // beeper bit 4, tape out bit 3
  localparam port_addr_t PORT_FE = 8'hFE;

  // empty flags in the high nibble, full flags in the low nibble
  localparam port_addr_t PORT_STATUS = 8'h3F;

  // beeper contribution per side
  localparam audio16_t BEEP_LEVEL = 16'd8192;

  // scales an 8-bit pair sum up into the 16-bit range
  localparam int CHAN_SCALE_SHIFT = 6;

endpackage

/* source/sound_port_decode.sv */
`timescale 1ns/10ps

module sound_port_decode (
  input  logic                                clk_28mhz,
  input  logic                                rst,
  input  sound_pkg::cpu_bus_t                 cpu_bus,
  input  logic [sound_pkg::NUM_CHANNELS-1:0]  chan_empty,
  input  logic [sound_pkg::NUM_CHANNELS-1:0]  chan_full,
  output logic [sound_pkg::NUM_CHANNELS-1:0]  chan_push,
  output sound_pkg::sample8_t                 push_data,
  output sound_pkg::sample8_t                 data_out,
  output logic                                data_oe,
  output logic                                beeper,
  output logic                                tape_out
);

  import sound_pkg::*;

  logic       io_wr;
  logic       io_rd;
  logic       fe_hit;
  logic [7:0] port_fe_reg;

  // qualified i/o cycles
  assign io_wr = cpu_bus.iorq && cpu_bus.wr;
  assign io_rd = cpu_bus.iorq && cpu_bus.rd;

  // channel pushes land in the queue on this same edge
  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      chan_push[i] = io_wr && (cpu_bus.addr == COVOX_PORTS[i]);
    end
  end

  // all channels share one data path, only the push bit selects
  assign push_data = cpu_bus.wdata;

  // port #FE register
  assign fe_hit = io_wr && (cpu_bus.addr == PORT_FE);

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      port_fe_reg <= '0;
    end else if (fe_hit) begin
      port_fe_reg <= cpu_bus.wdata;
    end
  end

  assign beeper   = port_fe_reg[4];
  assign tape_out = port_fe_reg[3];

  // status read is answered in the read cycle itself
  assign data_oe  = io_rd && (cpu_bus.addr == PORT_STATUS);
  assign data_out = data_oe ? {chan_empty, chan_full} : '0;

endmodule

/* audio/covox_channel.sv */
`timescale 1ns/10ps

module covox_channel #(
  parameter int DEPTH = 4
) (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  logic                push,
  input  sound_pkg::sample8_t push_data,
  input  logic                pop,
  output sound_pkg::sample8_t sample,
  output logic                empty,
  output logic                full
);

  import sound_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   LEVEL_FULL = (PTR_W + 1)'(DEPTH);

  sample8_t         mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   level;
  sample8_t         hold;
  logic             do_push;
  logic             do_pop;

  assign empty = (level == '0);
  assign full  = (level == LEVEL_FULL);

  // a push into a full queue is lost, a pop on empty does nothing
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk_28mhz) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      level  <= '0;
      hold   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
        hold   <= mem[rd_ptr];
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // head of queue, or the last popped value once drained
  assign sample = empty ? hold : mem[rd_ptr];

endmodule

/* audio/audio_mixer.sv */
`timescale 1ns/10ps

module audio_mixer #(
  parameter int SAMPLE_DIV = 640,
  parameter int CREDITS    = 4
) (
  input  logic                               clk_28mhz,
  input  logic                               rst,
  input  sound_pkg::sample8_t                chan_sample [sound_pkg::NUM_CHANNELS],
  input  logic                               beeper,
  input  logic                               credit_return,
  output logic [sound_pkg::NUM_CHANNELS-1:0] chan_pop,
  output sound_pkg::stereo_sample_t          sample_out,
  output logic                               sample_valid
);

  import sound_pkg::*;

  localparam int TICK_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(SAMPLE_DIV - 1);
  localparam int CRED_W = $clog2(CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(CREDITS);

  logic [TICK_W-1:0] tick_cnt;
  logic              tick;
  logic [CRED_W-1:0] credit_cnt;
  logic              have_credit;
  logic              fire;
  stereo_sample_t    next_mix;

  // channel pair sum scaled to 16 bits, beeper on top
  function automatic audio16_t mix_pair(
    input sample8_t a,
    input sample8_t b,
    input logic     beep
  );
    audio16_t sum;
    sum = (audio16_t'(a) + audio16_t'(b)) << CHAN_SCALE_SHIFT;
    if (beep) begin
      sum = sum + BEEP_LEVEL;
    end
    return sum;
  endfunction

  // sample rate divider
  assign tick = (tick_cnt == TICK_LAST);

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // without credit the tick is skipped and the queues keep their data
  assign have_credit = (credit_cnt != '0);
  assign fire        = tick && have_credit;

  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      chan_pop[i] = fire;
    end
  end

  assign next_mix.left  = mix_pair(chan_sample[0], chan_sample[1], beeper);
  assign next_mix.right = mix_pair(chan_sample[2], chan_sample[3], beeper);

  // output stage, valid one cycle after the tick
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= fire;
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (fire) begin
      sample_out <= next_mix;
    end
  end

  // one credit per sample sent, one back per sink pulse
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      credit_cnt <= CRED_MAX;
    end else begin
      case ({sample_valid, credit_return})
        2'b10: credit_cnt <= credit_cnt - 1'b1;
        2'b01: begin
          if (credit_cnt != CRED_MAX) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

/* source/sound_top.sv */
`timescale 1ns/10ps

module sound_top #(
  parameter int SAMPLE_DIV = 640,
  parameter int CREDITS    = 4,
  parameter int DEPTH      = 4
) (
  input  logic                      clk_28mhz,
  input  logic                      rst,
  input  sound_pkg::cpu_bus_t       cpu_bus,
  input  logic                      credit_return,
  output sound_pkg::sample8_t       data_out,
  output logic                      data_oe,
  output logic                      tape_out,
  output sound_pkg::stereo_sample_t sample_out,
  output logic                      sample_valid
);

  import sound_pkg::*;

  logic [NUM_CHANNELS-1:0] chan_push;
  logic [NUM_CHANNELS-1:0] chan_pop;
  logic [NUM_CHANNELS-1:0] chan_empty;
  logic [NUM_CHANNELS-1:0] chan_full;
  sample8_t                chan_sample [NUM_CHANNELS];
  sample8_t                push_data;
  logic                    beeper;

  sound_port_decode u_decode (
    .clk_28mhz  (clk_28mhz),
    .rst        (rst),
    .cpu_bus    (cpu_bus),
    .chan_empty (chan_empty),
    .chan_full  (chan_full),
    .chan_push  (chan_push),
    .push_data  (push_data),
    .data_out   (data_out),
    .data_oe    (data_oe),
    .beeper     (beeper),
    .tape_out   (tape_out)
  );

  // covox channels, one per port
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    covox_channel #(
      .DEPTH (DEPTH)
    ) u_chan (
      .clk_28mhz (clk_28mhz),
      .rst       (rst),
      .push      (chan_push[i]),
      .push_data (push_data),
      .pop       (chan_pop[i]),
      .sample    (chan_sample[i]),
      .empty     (chan_empty[i]),
      .full      (chan_full[i])
    );
  end

  audio_mixer #(
    .SAMPLE_DIV (SAMPLE_DIV),
    .CREDITS    (CREDITS)
  ) u_mixer (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .chan_sample   (chan_sample),
    .beeper        (beeper),
    .credit_return (credit_return),
    .chan_pop      (chan_pop),
    .sample_out    (sample_out),
    .sample_valid  (sample_valid)
  );

endmodule

/* verification/sound_chk.sv */
`timescale 1ns/10ps

module sound_chk #(
  parameter int CREDITS = 4
) (
  input logic                         clk_28mhz,
  input logic                         rst,
  input logic [$clog2(CREDITS+1)-1:0] credit_cnt,
  input logic                         sample_valid
);

  localparam int CW = $clog2(CREDITS + 1);
  localparam logic [CW-1:0] CRED_MAX = CW'(CREDITS);

  // sink never hands back more than it was given
  a_credit_bound: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    credit_cnt <= CRED_MAX
  ) else $error("credit counter above its reset value");

  a_valid_needs_credit: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    $rose(sample_valid) |-> credit_cnt != '0
  ) else $error("sample_valid raised with no credit");

  a_valid_one_cycle: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    sample_valid |=> !sample_valid
  ) else $error("sample_valid held longer than one cycle");

endmodule

bind audio_mixer sound_chk #(
  .CREDITS (CREDITS)
) u_sound_chk (
  .clk_28mhz    (clk_28mhz),
  .rst          (rst),
  .credit_cnt   (credit_cnt),
  .sample_valid (sample_valid)
);

/* verification/tb_sound.sv */
`timescale 1ns/10ps

module tb_sound;

  import sound_pkg::*;

  localparam int SAMPLE_DIV  = 16;
  localparam int CREDITS     = 4;
  localparam int DEPTH       = 4;
  localparam int CLK_PERIOD  = 4;
  localparam int NUM_TESTS   = 5;
  localparam int WATCHDOG_NS = NUM_TESTS * 64 * SAMPLE_DIV * CLK_PERIOD;

  logic           clk_28mhz = 1'b0;
  logic           rst;
  cpu_bus_t       cpu_bus;
  logic           credit_return = 1'b0;
  sample8_t       data_out;
  logic           data_oe;
  logic           tape_out;
  stereo_sample_t sample_out;
  logic           sample_valid;

  stereo_sample_t captured [$];
  int             owed = 0;
  bit             credits_on = 1'b1;
  int             errors = 0;
  logic [31:0]    rng_state = 32'h3469;
  sample8_t       hold_val [NUM_CHANNELS];
  logic           beep_on;

  sound_top #(
    .SAMPLE_DIV (SAMPLE_DIV),
    .CREDITS    (CREDITS),
    .DEPTH      (DEPTH)
  ) UUT (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .cpu_bus       (cpu_bus),
    .credit_return (credit_return),
    .data_out      (data_out),
    .data_oe       (data_oe),
    .tape_out      (tape_out),
    .sample_out    (sample_out),
    .sample_valid  (sample_valid)
  );

  always #(CLK_PERIOD / 2) clk_28mhz = ~clk_28mhz;

  always @(posedge clk_28mhz) begin
    if (!rst && sample_valid) begin
      captured.push_back(sample_out);
    end
  end

  // sink owes a credit per sample and pays it back while credits_on is set
  always @(posedge clk_28mhz) begin
    if (rst) begin
      owed          <= 0;
      credit_return <= 1'b0;
    end else begin
      if (credits_on && owed > 0) begin
        credit_return <= 1'b1;
        owed          <= owed - 1 + int'(sample_valid);
      end else begin
        credit_return <= 1'b0;
        owed          <= owed + int'(sample_valid);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d errors, tests did not finish",
             WATCHDOG_NS, errors);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic sample8_t rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  function automatic cpu_bus_t make_bus(input port_addr_t addr, input sample8_t data,
                                        input logic rd, input logic wr);
    cpu_bus_t b;
    b.addr  = addr;
    b.wdata = data;
    b.iorq  = rd | wr;
    b.rd    = rd;
    b.wr    = wr;
    return b;
  endfunction

  // one side of the mix: pair sum scaled up, beeper level on top
  function automatic audio16_t mix_side(input sample8_t a, input sample8_t b, input logic beep);
    int level;
    level = (int'(a) + int'(b)) * (2 ** CHAN_SCALE_SHIFT);
    if (beep) begin
      level = level + int'(BEEP_LEVEL);
    end
    return audio16_t'(level);
  endfunction

  task automatic io_write(input port_addr_t addr, input sample8_t data);
    @(posedge clk_28mhz);
    cpu_bus <= make_bus(addr, data, 1'b0, 1'b1);
  endtask

  task automatic release_bus();
    @(posedge clk_28mhz);
    cpu_bus <= make_bus(8'h00, 8'h00, 1'b0, 1'b0);
  endtask

  task automatic read_status(input sample8_t expected);
    @(posedge clk_28mhz);
    cpu_bus <= make_bus(PORT_STATUS, 8'h00, 1'b1, 1'b0);
    @(negedge clk_28mhz);
    if (data_oe !== 1'b1) begin
      $display("Error at %0t ns: data_oe expected 1, got %b", $time, data_oe);
      errors++;
    end
    if (data_out !== expected) begin
      $display("Error at %0t ns: data_out expected %h, got %h", $time, expected, data_out);
      errors++;
    end
    release_bus();
  endtask

  task automatic next_sample(output stereo_sample_t s, output bit ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    s = '0;
    while (!ok && waited < 3 * SAMPLE_DIV) begin
      @(negedge clk_28mhz);
      if (captured.size() != 0) begin
        s  = captured.pop_front();
        ok = 1'b1;
      end
      waited++;
    end
    if (!ok) begin
      $display("Error at %0t ns: no sample arrived within %0d cycles", $time, 3 * SAMPLE_DIV);
      errors++;
    end
  endtask

  task automatic expect_sample();
    stereo_sample_t got;
    bit             ok;
    audio16_t       exp_left;
    audio16_t       exp_right;
    exp_left  = mix_side(hold_val[0], hold_val[1], beep_on);
    exp_right = mix_side(hold_val[2], hold_val[3], beep_on);
    next_sample(got, ok);
    if (ok && got.left !== exp_left) begin
      $display("Error at %0t ns: sample_out.left expected %h, got %h", $time, exp_left, got.left);
      errors++;
    end
    if (ok && got.right !== exp_right) begin
      $display("Error at %0t ns: sample_out.right expected %h, got %h",
               $time, exp_right, got.right);
      errors++;
    end
  endtask

  // drop older samples so the next one starts a fresh sample period
  task automatic resync_samples();
    captured.delete();
    expect_sample();
  endtask

  task automatic after_reset();
    if (sample_valid !== 1'b0) begin
      $display("Error at %0t ns: sample_valid expected 0, got %b", $time, sample_valid);
      errors++;
    end
    if (tape_out !== 1'b0) begin
      $display("Error at %0t ns: tape_out expected 0, got %b", $time, tape_out);
      errors++;
    end
    if (data_oe !== 1'b0) begin
      $display("Error at %0t ns: data_oe expected 0, got %b", $time, data_oe);
      errors++;
    end
    read_status(8'hF0);
  endtask

  task automatic single_writes();
    sample8_t val;
    resync_samples();
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      val = rand_byte();
      io_write(COVOX_PORTS[ch], val);
      hold_val[ch] = val;
    end
    release_bus();
    expect_sample();
    expect_sample();
  endtask

  task automatic queue_overflow();
    sample8_t vals [DEPTH + 1];
    resync_samples();
    for (int k = 0; k < DEPTH + 1; k++) begin
      vals[k] = rand_byte();
      io_write(COVOX_PORTS[0], vals[k]);
    end
    // channel 0 full, the others drained
    read_status(8'hE1);
    for (int k = 0; k < DEPTH; k++) begin
      hold_val[0] = vals[k];
      expect_sample();
    end
    // last write was dropped, hold keeps the fourth value
    expect_sample();
  endtask

  task automatic beeper_and_tape();
    resync_samples();
    io_write(PORT_FE, 8'h10);
    release_bus();
    beep_on = 1'b1;
    expect_sample();
    expect_sample();
    io_write(PORT_FE, 8'h18);
    release_bus();
    @(negedge clk_28mhz);
    if (tape_out !== 1'b1) begin
      $display("Error at %0t ns: tape_out expected 1, got %b", $time, tape_out);
      errors++;
    end
    expect_sample();
    io_write(PORT_FE, 8'h00);
    release_bus();
    beep_on = 1'b0;
    @(negedge clk_28mhz);
    if (tape_out !== 1'b0) begin
      $display("Error at %0t ns: tape_out expected 0, got %b", $time, tape_out);
      errors++;
    end
  endtask

  task automatic back_pressure();
    sample8_t vals [2 * DEPTH];
    resync_samples();
    // credit for the sync sample comes back before the sink stops
    repeat (6) @(negedge clk_28mhz);
    credits_on = 1'b0;
    for (int k = 0; k < 2 * DEPTH; k++) begin
      vals[k] = rand_byte();
    end
    for (int k = 0; k < DEPTH; k++) begin
      io_write(COVOX_PORTS[0], vals[k]);
    end
    release_bus();
    // each sample frees one queue slot for the next value
    for (int k = 0; k < CREDITS; k++) begin
      hold_val[0] = vals[k];
      expect_sample();
      io_write(COVOX_PORTS[0], vals[DEPTH + k]);
      release_bus();
    end
    repeat (4 * SAMPLE_DIV) @(negedge clk_28mhz);
    if (captured.size() != 0) begin
      $display("Error at %0t ns: %0d samples were sent with no credit left",
               $time, captured.size());
      errors++;
    end
    read_status(8'hE1);
    credits_on = 1'b1;
    for (int k = DEPTH; k < 2 * DEPTH; k++) begin
      hold_val[0] = vals[k];
      expect_sample();
    end
    expect_sample();
  endtask

  initial begin
    rst     = 1'b1;
    cpu_bus = make_bus(8'h00, 8'h00, 1'b0, 1'b0);
    beep_on = 1'b0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      hold_val[i] = '0;
    end
    repeat (4) @(posedge clk_28mhz);
    rst <= 1'b0;
    @(negedge clk_28mhz);
    after_reset();
    single_writes();
    queue_overflow();
    beeper_and_tape();
    back_pressure();
    $display("tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
common/sound_pkg.sv
source/sound_port_decode.sv
audio/covox_channel.sv
audio/audio_mixer.sv
source/sound_top.sv
verification/sound_chk.sv
verification/tb_sound.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sound path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f flist.f --top-module tb_sound -Mdir "$BUILD_DIR" -o tb_sound
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sound" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
